/* axi_delay.f */
axi_delay_pkg.sv
axi_delayer.sv
axi_sram_slave.sv
axi_delay_top.sv
tb_axi_delay_assert.sv
tb_axi_delay.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_axi_delay
FILELIST = axi_delay.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP), pass decided from $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_axi_delay.sv */
`timescale 1ns/1ps
module tb_axi_delay;

  localparam int TIMEOUT = 300;
  localparam int WW = axi_delay_pkg::WORD_W;

  logic clock, reset;
  logic arready, arvalid, rready, rvalid, rlast;
  logic awready, awvalid, wready, wvalid, wlast, bready, bvalid;
  logic [axi_delay_pkg::ID_W-1:0]    arid, rid, awid, bid;
  logic [axi_delay_pkg::ADDR_W-1:0]  araddr, awaddr;
  logic [axi_delay_pkg::LEN_W-1:0]   arlen, awlen;
  logic [2:0]                        arsize, awsize;
  logic [1:0]                        arburst, awburst;
  logic [axi_delay_pkg::DATA_W-1:0]  rdata, wdata;
  logic [axi_delay_pkg::STRB_W-1:0]  wstrb;
  logic [axi_delay_pkg::RESP_W-1:0]  rresp, bresp;

  logic [axi_delay_pkg::DATA_W-1:0]  model [axi_delay_pkg::MEM_WORDS];
  logic [31:0] lfsr;
  int cyc;
  int data_errs, id_errs, resp_errs, flag_errs, timeout_errs, rule_errs;

  axi_delay_top u_axi_delay_top (.*);

  always #2 clock = ~clock;
  always @(posedge clock) cyc <= cyc + 1;

  // galois lfsr, one step per bit.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic logic pick_ready(input logic stall);
    logic [31:0] r;
    if (!stall)
      return 1'b1;
    r = rand_bits(2);
    return r[1:0] != 2'b00;  // ready three times in four.
  endfunction

  function automatic logic [3:0] pick_region(input logic slow);
    logic [31:0] r;
    r = rand_bits(4);
    if (slow)
      return {3'b101, r[0]};
    if (r[3:0] == 4'ha || r[3:0] == 4'hb)
      return r[3:0] ^ 4'h4;
    return r[3:0];
  endfunction

  function automatic logic [31:0] make_addr(input logic [3:0] region, input logic [WW-1:0] w);
    axi_delay_pkg::axi_addr_u a;
    a = '0;
    a.mem_view.word = w;
    a.region_view.region = region;
    return a;
  endfunction

  function automatic logic [31:0] fill_word(input logic [WW-1:0] w);
    return {w, ~w, w ^ 8'h5a, w + 8'h3c};
  endfunction

  task automatic check_data(input string name, input logic [axi_delay_pkg::DATA_W-1:0] exp,
                            input logic [axi_delay_pkg::DATA_W-1:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      data_errs++;
    end
  endtask

  task automatic check_id(input string name, input logic [axi_delay_pkg::ID_W-1:0] exp,
                          input logic [axi_delay_pkg::ID_W-1:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      id_errs++;
    end
  endtask

  task automatic check_resp(input string name, input logic [axi_delay_pkg::RESP_W-1:0] exp,
                            input logic [axi_delay_pkg::RESP_W-1:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      resp_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      flag_errs++;
    end
  endtask

  task automatic drive_addr(input logic rd, input logic [31:0] addr,
                            input logic [7:0] len, input logic [3:0] id);
    @(posedge clock);
    if (rd) begin
      arvalid <= 1'b1;
      araddr <= addr;
      arlen <= len;
      arid <= id;
    end else begin
      awvalid <= 1'b1;
      awaddr <= addr;
      awlen <= len;
      awid <= id;
    end
  endtask

  // returns on the transfer edge with valid dropped.
  task automatic wait_accept(input logic rd, output int t0);
    int n;
    n = 0;
    @(negedge clock);
    while (!(rd ? arready : awready) && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (!(rd ? arready : awready)) begin
      $display("timeout: %s address was never accepted", rd ? "read" : "write");
      timeout_errs++;
    end
    t0 = cyc;
    @(posedge clock);
    if (rd)
      arvalid <= 1'b0;
    else
      awvalid <= 1'b0;
  endtask

  task automatic collect_r(input logic [WW-1:0] w, input logic [7:0] len, input logic [3:0] id,
                           input logic stall, input logic probe, output int t_end);
    int beat;
    int n;
    logic [WW-1:0] bw;
    beat = 0;
    n = 0;
    t_end = cyc;
    rready <= pick_ready(stall);
    while (beat <= int'(len) && n < TIMEOUT) begin
      @(negedge clock);
      n++;
      if (probe && arready) begin
        $display("read address accepted while a delayed read was outstanding");
        rule_errs++;
      end
      if (rvalid && rready) begin
        bw = w + WW'(beat);
        check_data("rdata", model[bw], rdata);
        check_id("rid", id, rid);
        check_resp("rresp", axi_delay_pkg::RESP_OKAY, rresp);
        check_flag("rlast", beat == int'(len), rlast);
        beat++;
        t_end = cyc;
      end
      @(posedge clock);
      rready <= pick_ready(stall);
    end
    rready <= 1'b0;
    if (beat <= int'(len)) begin
      $display("timeout: read burst ended after %0d of %0d beats", beat, len + 1);
      timeout_errs++;
    end
  endtask

  task automatic send_w(input logic [WW-1:0] w, input logic [7:0] len, input logic fill);
    int n;
    logic [31:0] r;
    logic [WW-1:0] bw;
    logic [31:0] d;
    logic [3:0] s;
    for (int i = 0; i <= int'(len); i++) begin
      bw = w + WW'(i);
      r = rand_bits(32);
      d = fill ? fill_word(bw) : r;
      r = rand_bits(4);
      s = fill ? 4'hf : r[3:0];
      for (int k = 0; k < axi_delay_pkg::STRB_W; k++)
        if (s[k])
          model[bw][8*k +: 8] = d[8*k +: 8];
      wvalid <= 1'b1;
      wdata <= d;
      wstrb <= s;
      wlast <= (i == int'(len));
      n = 0;
      @(negedge clock);
      while (!wready && n < TIMEOUT) begin
        @(negedge clock);
        n++;
      end
      if (!wready) begin
        $display("timeout: write beat %0d was never accepted", i);
        timeout_errs++;
      end
      @(posedge clock);
    end
    wvalid <= 1'b0;
    wlast <= 1'b0;
  endtask

  task automatic collect_b(input logic [3:0] id, input logic stall, output int t_end);
    int n;
    logic done;
    n = 0;
    done = 1'b0;
    t_end = cyc;
    bready <= pick_ready(stall);
    while (!done && n < TIMEOUT) begin
      @(negedge clock);
      n++;
      if (bvalid && bready) begin
        check_id("bid", id, bid);
        check_resp("bresp", axi_delay_pkg::RESP_OKAY, bresp);
        done = 1'b1;
        t_end = cyc;
      end
      @(posedge clock);
      bready <= pick_ready(stall);
    end
    bready <= 1'b0;
    if (!done) begin
      $display("timeout: write response never arrived");
      timeout_errs++;
    end
  endtask

  task automatic check_bound(input logic [3:0] region, input int elapsed, input logic [7:0] len);
    if ((region == 4'ha || region == 4'hb) &&
        elapsed < axi_delay_pkg::RATIO_R * (int'(len) + 1)) begin
      $display("delayed burst of %0d beats completed in only %0d cycles", len + 1, elapsed);
      rule_errs++;
    end
  endtask

  task automatic read_burst(input logic [3:0] region, input logic [WW-1:0] w,
                            input logic [7:0] len, input logic [3:0] id, input logic stall,
                            output int elapsed);
    int t0, t1;
    drive_addr(1'b1, make_addr(region, w), len, id);
    wait_accept(1'b1, t0);
    collect_r(w, len, id, stall, 1'b0, t1);
    elapsed = t1 - t0;
    check_bound(region, elapsed, len);
  endtask

  task automatic write_burst(input logic [3:0] region, input logic [WW-1:0] w,
                             input logic [7:0] len, input logic [3:0] id, input logic stall,
                             input logic fill, output int elapsed);
    int t0, t1;
    drive_addr(1'b0, make_addr(region, w), len, id);
    wait_accept(1'b0, t0);
    send_w(w, len, fill);
    collect_b(id, stall, t1);
    elapsed = t1 - t0;
    check_bound(region, elapsed, len);
  endtask

  initial begin
    logic [31:0] r;
    logic [WW-1:0] w;
    logic [7:0] len;
    logic [3:0] id;
    int el, el_p;
    int t0, t1;
    clock = 1'b0;
    reset = 1'b1;
    cyc = 0;
    lfsr = 32'd22;
    {data_errs, id_errs, resp_errs, flag_errs, timeout_errs, rule_errs} = '0;
    {arvalid, rready, awvalid, wvalid, wlast, bready} = '0;
    arid = '0;
    awid = '0;
    araddr = '0;
    awaddr = '0;
    arlen = '0;
    awlen = '0;
    arsize = 3'd2;
    awsize = 3'd2;
    arburst = 2'b01;
    awburst = 2'b01;
    wdata = '0;
    wstrb = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    for (int b = 0; b < axi_delay_pkg::MEM_WORDS / 8; b++)
      write_burst(4'h0, WW'(b * 8), 8'd7, 4'h0, 1'b0, 1'b1, el);

    repeat (4) begin  // passthrough write then read.
      r = rand_bits(15);
      w = r[7:0];
      len = {5'b0, r[10:8]};
      id = r[14:11];
      write_burst(pick_region(1'b0), w, len, id, 1'b0, 1'b0, el);
      read_burst(pick_region(1'b0), w, len, ~id, 1'b0, el);
    end

    for (int l = 0; l < axi_delay_pkg::BUF_DEPTH; l++) begin
      r = rand_bits(12);
      read_burst(pick_region(1'b1), r[7:0], 8'(l), r[11:8], r[0], el);
    end

    repeat (4) begin  // delayed write, read back through an alias.
      r = rand_bits(15);
      w = r[7:0];
      len = {5'b0, r[10:8]};
      id = r[14:11];
      write_burst(pick_region(1'b1), w, len, id, 1'b0, 1'b0, el);
      read_burst(pick_region(1'b0), w, len, id, 1'b0, el);
    end

    for (int l = 0; l < axi_delay_pkg::BUF_DEPTH; l++) begin
      r = rand_bits(12);
      read_burst(pick_region(1'b1), r[7:0], 8'(l), r[11:8], 1'b0, el);
      read_burst(pick_region(1'b0), r[7:0], 8'(l), r[11:8], 1'b0, el_p);
      if (el_p >= el) begin
        $display("passthrough read took %0d cycles, delayed only %0d", el_p, el);
        rule_errs++;
      end
    end

    repeat (30) begin  // mixed traffic with ready stalls.
      r = rand_bits(17);
      w = r[7:0];
      len = {5'b0, r[10:8]};
      id = r[14:11];
      if (r[15])
        write_burst(pick_region(r[16]), w, len, id, 1'b1, 1'b0, el);
      else
        read_burst(pick_region(r[16]), w, len, id, 1'b1, el);
    end

    // second address waits behind a delayed read.
    drive_addr(1'b1, make_addr(4'ha, 8'h40), 8'd3, 4'h5);
    wait_accept(1'b1, t0);
    arvalid <= 1'b1;
    araddr <= make_addr(4'h2, 8'h80);
    arlen <= 8'd1;
    arid <= 4'h9;
    collect_r(8'h40, 8'd3, 4'h5, 1'b1, 1'b1, t1);
    wait_accept(1'b1, t0);
    collect_r(8'h80, 8'd1, 4'h9, 1'b0, 1'b0, t1);

    repeat (4) @(posedge clock);
    $display("errors: data %0d id %0d resp %0d flag %0d timeout %0d rule %0d",
             data_errs, id_errs, resp_errs, flag_errs, timeout_errs, rule_errs);
    if (data_errs + id_errs + resp_errs + flag_errs + timeout_errs + rule_errs == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* tb_axi_delay_assert.sv */
`timescale 1ns/1ps
module axi_delay_assert (
  input logic                              clock,
  input logic                              reset,
  input logic                              in_arvalid,
  input logic [axi_delay_pkg::ADDR_W-1:0]  in_araddr,
  input logic                              in_awvalid,
  input logic [axi_delay_pkg::ADDR_W-1:0]  in_awaddr,
  input logic                              in_rvalid,
  input logic                              in_rready,
  input logic                              in_rlast,
  input logic [axi_delay_pkg::DATA_W-1:0]  in_rdata,
  input logic [axi_delay_pkg::ID_W-1:0]    in_rid,
  input logic                              in_arready,
  input logic                              in_awready,
  input logic                              in_bvalid,
  input logic                              in_bready,
  input logic                              out_rvalid,
  input logic                              out_rready,
  input logic                              out_rlast,
  input logic                              out_bvalid,
  input logic                              out_bready
);

  logic busy;        // delayed transaction in flight.
  logic slave_done;  // slave side already answered.
  logic ar_slow, aw_slow, start, slave_end, master_end;

  assign ar_slow = (in_araddr[axi_delay_pkg::ADDR_W-1 -: 4] == axi_delay_pkg::DELAY_REGION_LO) ||
                   (in_araddr[axi_delay_pkg::ADDR_W-1 -: 4] == axi_delay_pkg::DELAY_REGION_HI);
  assign aw_slow = (in_awaddr[axi_delay_pkg::ADDR_W-1 -: 4] == axi_delay_pkg::DELAY_REGION_LO) ||
                   (in_awaddr[axi_delay_pkg::ADDR_W-1 -: 4] == axi_delay_pkg::DELAY_REGION_HI);

  assign start = (in_arvalid && in_arready && ar_slow) || (in_awvalid && in_awready && aw_slow);
  assign slave_end = (out_rvalid && out_rready && out_rlast) || (out_bvalid && out_bready);
  assign master_end = (in_rvalid && in_rready && in_rlast) || (in_bvalid && in_bready);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      slave_done <= 1'b0;
    end else if (!busy) begin
      busy <= start;
      slave_done <= 1'b0;
    end else begin
      if (slave_end)
        slave_done <= 1'b1;
      if (master_end)
        busy <= 1'b0;
    end
  end

  // a stalled beat keeps its payload.
  a_r_stable: assert property (@(posedge clock) disable iff (reset)
    in_rvalid && !in_rready |=> in_rvalid && $stable(in_rdata) && $stable(in_rid) &&
                                $stable(in_rlast))
    else $error("read beat changed while stalled");

  a_addr_blocked: assert property (@(posedge clock) disable iff (reset)
    busy |-> !in_arready && !in_awready)
    else $error("address ready during a delayed transaction");

  a_resp_in_wait: assert property (@(posedge clock) disable iff (reset)
    busy && (in_rvalid || in_bvalid) |-> slave_done)
    else $error("delayed response shown before the slave finished");

endmodule

bind axi_delayer axi_delay_assert u_assert (
  .clock(clock), .reset(reset),
  .in_arvalid(in_arvalid), .in_araddr(in_araddr),
  .in_awvalid(in_awvalid), .in_awaddr(in_awaddr),
  .in_rvalid(in_rvalid), .in_rready(in_rready), .in_rlast(in_rlast),
  .in_rdata(in_rdata), .in_rid(in_rid),
  .in_arready(in_arready), .in_awready(in_awready),
  .in_bvalid(in_bvalid), .in_bready(in_bready),
  .out_rvalid(out_rvalid), .out_rready(out_rready), .out_rlast(out_rlast),
  .out_bvalid(out_bvalid), .out_bready(out_bready)
);

/* axi_delay_top.sv */
`timescale 1ns/1ps
module axi_delay_top (
  input  logic                              clock,
  input  logic                              reset,

  output logic                              arready,
  input  logic                              arvalid,
  input  logic [axi_delay_pkg::ID_W-1:0]    arid,
  input  logic [axi_delay_pkg::ADDR_W-1:0]  araddr,
  input  logic [axi_delay_pkg::LEN_W-1:0]   arlen,
  input  logic [2:0]                        arsize,
  input  logic [1:0]                        arburst,
  input  logic                              rready,
  output logic                              rvalid,
  output logic [axi_delay_pkg::ID_W-1:0]    rid,
  output logic [axi_delay_pkg::DATA_W-1:0]  rdata,
  output logic [axi_delay_pkg::RESP_W-1:0]  rresp,
  output logic                              rlast,
  output logic                              awready,
  input  logic                              awvalid,
  input  logic [axi_delay_pkg::ID_W-1:0]    awid,
  input  logic [axi_delay_pkg::ADDR_W-1:0]  awaddr,
  input  logic [axi_delay_pkg::LEN_W-1:0]   awlen,
  input  logic [2:0]                        awsize,
  input  logic [1:0]                        awburst,
  output logic                              wready,
  input  logic                              wvalid,
  input  logic [axi_delay_pkg::DATA_W-1:0]  wdata,
  input  logic [axi_delay_pkg::STRB_W-1:0]  wstrb,
  input  logic                              wlast,
  input  logic                              bready,
  output logic                              bvalid,
  output logic [axi_delay_pkg::ID_W-1:0]    bid,
  output logic [axi_delay_pkg::RESP_W-1:0]  bresp
);

  // slave side of the delayer.
  logic mem_arready, mem_arvalid, mem_rready, mem_rvalid, mem_rlast;
  logic mem_awready, mem_awvalid, mem_wready, mem_wvalid, mem_wlast;
  logic mem_bready, mem_bvalid;
  logic [axi_delay_pkg::ID_W-1:0]    mem_arid, mem_rid, mem_awid, mem_bid;
  logic [axi_delay_pkg::ADDR_W-1:0]  mem_araddr, mem_awaddr;
  logic [axi_delay_pkg::LEN_W-1:0]   mem_arlen, mem_awlen;
  logic [2:0]                        mem_arsize, mem_awsize;
  logic [1:0]                        mem_arburst, mem_awburst;
  logic [axi_delay_pkg::DATA_W-1:0]  mem_rdata, mem_wdata;
  logic [axi_delay_pkg::STRB_W-1:0]  mem_wstrb;
  logic [axi_delay_pkg::RESP_W-1:0]  mem_rresp, mem_bresp;

  axi_delayer u_delayer (
    .clock(clock), .reset(reset),
    .in_arready(arready), .in_arvalid(arvalid), .in_arid(arid), .in_araddr(araddr),
    .in_arlen(arlen), .in_arsize(arsize), .in_arburst(arburst),
    .in_rready(rready), .in_rvalid(rvalid), .in_rid(rid), .in_rdata(rdata),
    .in_rresp(rresp), .in_rlast(rlast),
    .in_awready(awready), .in_awvalid(awvalid), .in_awid(awid), .in_awaddr(awaddr),
    .in_awlen(awlen), .in_awsize(awsize), .in_awburst(awburst),
    .in_wready(wready), .in_wvalid(wvalid), .in_wdata(wdata), .in_wstrb(wstrb),
    .in_wlast(wlast),
    .in_bready(bready), .in_bvalid(bvalid), .in_bid(bid), .in_bresp(bresp),
    .out_arready(mem_arready), .out_arvalid(mem_arvalid), .out_arid(mem_arid),
    .out_araddr(mem_araddr), .out_arlen(mem_arlen), .out_arsize(mem_arsize),
    .out_arburst(mem_arburst),
    .out_rready(mem_rready), .out_rvalid(mem_rvalid), .out_rid(mem_rid),
    .out_rdata(mem_rdata), .out_rresp(mem_rresp), .out_rlast(mem_rlast),
    .out_awready(mem_awready), .out_awvalid(mem_awvalid), .out_awid(mem_awid),
    .out_awaddr(mem_awaddr), .out_awlen(mem_awlen), .out_awsize(mem_awsize),
    .out_awburst(mem_awburst),
    .out_wready(mem_wready), .out_wvalid(mem_wvalid), .out_wdata(mem_wdata),
    .out_wstrb(mem_wstrb), .out_wlast(mem_wlast),
    .out_bready(mem_bready), .out_bvalid(mem_bvalid), .out_bid(mem_bid),
    .out_bresp(mem_bresp)
  );

  axi_sram_slave u_mem (.*);  // mem_ names match the slave ports.

endmodule

/* axi_sram_slave.sv */
`timescale 1ns/1ps
module axi_sram_slave (
  input  logic                              clock,
  input  logic                              reset,

  output logic                              mem_arready,
  input  logic                              mem_arvalid,
  input  logic [axi_delay_pkg::ID_W-1:0]    mem_arid,
  input  logic [axi_delay_pkg::ADDR_W-1:0]  mem_araddr,
  input  logic [axi_delay_pkg::LEN_W-1:0]   mem_arlen,
  input  logic [2:0]                        mem_arsize,
  input  logic [1:0]                        mem_arburst,
  input  logic                              mem_rready,
  output logic                              mem_rvalid,
  output logic [axi_delay_pkg::ID_W-1:0]    mem_rid,
  output logic [axi_delay_pkg::DATA_W-1:0]  mem_rdata,
  output logic [axi_delay_pkg::RESP_W-1:0]  mem_rresp,
  output logic                              mem_rlast,
  output logic                              mem_awready,
  input  logic                              mem_awvalid,
  input  logic [axi_delay_pkg::ID_W-1:0]    mem_awid,
  input  logic [axi_delay_pkg::ADDR_W-1:0]  mem_awaddr,
  input  logic [axi_delay_pkg::LEN_W-1:0]   mem_awlen,
  input  logic [2:0]                        mem_awsize,
  input  logic [1:0]                        mem_awburst,
  output logic                              mem_wready,
  input  logic                              mem_wvalid,
  input  logic [axi_delay_pkg::DATA_W-1:0]  mem_wdata,
  input  logic [axi_delay_pkg::STRB_W-1:0]  mem_wstrb,
  input  logic                              mem_wlast,
  input  logic                              mem_bready,
  output logic                              mem_bvalid,
  output logic [axi_delay_pkg::ID_W-1:0]    mem_bid,
  output logic [axi_delay_pkg::RESP_W-1:0]  mem_bresp
);

  logic [axi_delay_pkg::DATA_W-1:0]  mem [axi_delay_pkg::MEM_WORDS];
  axi_delay_pkg::axi_addr_u          ar_addr;
  axi_delay_pkg::axi_addr_u          aw_addr;
  logic [axi_delay_pkg::WORD_W-1:0]  rd_word;
  logic [axi_delay_pkg::WORD_W-1:0]  wr_word;
  logic [axi_delay_pkg::LEN_W-1:0]   rd_len;
  logic [axi_delay_pkg::LEN_W-1:0]   rd_cnt;
  logic [axi_delay_pkg::ID_W-1:0]    rd_id;
  logic [axi_delay_pkg::ID_W-1:0]    wr_id;
  logic                              wr_active;
  logic ar_fire, r_fire, aw_fire, w_fire, b_fire;

  assign ar_addr = mem_araddr;
  assign aw_addr = mem_awaddr;

  assign ar_fire = mem_arvalid & mem_arready;
  assign r_fire = mem_rvalid & mem_rready;
  assign aw_fire = mem_awvalid & mem_awready;
  assign w_fire = mem_wvalid & mem_wready;
  assign b_fire = mem_bvalid & mem_bready;

  // read engine, one beat per cycle from the current word.
  assign mem_rid = rd_id;
  assign mem_rdata = mem[rd_word];
  assign mem_rresp = axi_delay_pkg::RESP_OKAY;
  assign mem_rlast = (rd_cnt == rd_len);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mem_arready <= 1'b0;
      mem_rvalid <= 1'b0;
      rd_cnt <= '0;
    end else begin
      mem_arready <= mem_arvalid & ~mem_arready & ~mem_rvalid;  // one-cycle pulse.
      if (ar_fire) begin
        mem_rvalid <= 1'b1;
        rd_cnt <= '0;
      end else if (r_fire) begin
        if (mem_rlast)
          mem_rvalid <= 1'b0;
        rd_cnt <= rd_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rd_id <= mem_arid;
      rd_word <= ar_addr.mem_view.word;
      rd_len <= mem_arlen;
    end else if (r_fire) begin
      rd_word <= rd_word + 1'b1;  // INCR for every burst type.
    end
  end

  // write engine.
  assign mem_wready = wr_active;
  assign mem_bid = wr_id;
  assign mem_bresp = axi_delay_pkg::RESP_OKAY;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mem_awready <= 1'b0;
      wr_active <= 1'b0;
      mem_bvalid <= 1'b0;
    end else begin
      mem_awready <= mem_awvalid & ~mem_awready & ~wr_active & ~mem_bvalid;
      if (aw_fire)
        wr_active <= 1'b1;
      else if (w_fire && mem_wlast)
        wr_active <= 1'b0;
      if (w_fire && mem_wlast)
        mem_bvalid <= 1'b1;
      else if (b_fire)
        mem_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (aw_fire) begin
      wr_id <= mem_awid;
      wr_word <= aw_addr.mem_view.word;
    end else if (w_fire) begin
      wr_word <= wr_word + 1'b1;
    end
    if (w_fire) begin
      for (int i = 0; i < axi_delay_pkg::STRB_W; i++) begin
        if (mem_wstrb[i])
          mem[wr_word][8*i +: 8] <= mem_wdata[8*i +: 8];
      end
    end
  end

endmodule

/* axi_delayer.sv */
`timescale 1ns/1ps
module axi_delayer (
  input  logic                              clock,
  input  logic                              reset,

  output logic                              in_arready,
  input  logic                              in_arvalid,
  input  logic [axi_delay_pkg::ID_W-1:0]    in_arid,
  input  logic [axi_delay_pkg::ADDR_W-1:0]  in_araddr,
  input  logic [axi_delay_pkg::LEN_W-1:0]   in_arlen,
  input  logic [2:0]                        in_arsize,
  input  logic [1:0]                        in_arburst,
  input  logic                              in_rready,
  output logic                              in_rvalid,
  output logic [axi_delay_pkg::ID_W-1:0]    in_rid,
  output logic [axi_delay_pkg::DATA_W-1:0]  in_rdata,
  output logic [axi_delay_pkg::RESP_W-1:0]  in_rresp,
  output logic                              in_rlast,
  output logic                              in_awready,
  input  logic                              in_awvalid,
  input  logic [axi_delay_pkg::ID_W-1:0]    in_awid,
  input  logic [axi_delay_pkg::ADDR_W-1:0]  in_awaddr,
  input  logic [axi_delay_pkg::LEN_W-1:0]   in_awlen,
  input  logic [2:0]                        in_awsize,
  input  logic [1:0]                        in_awburst,
  output logic                              in_wready,
  input  logic                              in_wvalid,
  input  logic [axi_delay_pkg::DATA_W-1:0]  in_wdata,
  input  logic [axi_delay_pkg::STRB_W-1:0]  in_wstrb,
  input  logic                              in_wlast,
  input  logic                              in_bready,
  output logic                              in_bvalid,
  output logic [axi_delay_pkg::ID_W-1:0]    in_bid,
  output logic [axi_delay_pkg::RESP_W-1:0]  in_bresp,

  input  logic                              out_arready,
  output logic                              out_arvalid,
  output logic [axi_delay_pkg::ID_W-1:0]    out_arid,
  output logic [axi_delay_pkg::ADDR_W-1:0]  out_araddr,
  output logic [axi_delay_pkg::LEN_W-1:0]   out_arlen,
  output logic [2:0]                        out_arsize,
  output logic [1:0]                        out_arburst,
  output logic                              out_rready,
  input  logic                              out_rvalid,
  input  logic [axi_delay_pkg::ID_W-1:0]    out_rid,
  input  logic [axi_delay_pkg::DATA_W-1:0]  out_rdata,
  input  logic [axi_delay_pkg::RESP_W-1:0]  out_rresp,
  input  logic                              out_rlast,
  input  logic                              out_awready,
  output logic                              out_awvalid,
  output logic [axi_delay_pkg::ID_W-1:0]    out_awid,
  output logic [axi_delay_pkg::ADDR_W-1:0]  out_awaddr,
  output logic [axi_delay_pkg::LEN_W-1:0]   out_awlen,
  output logic [2:0]                        out_awsize,
  output logic [1:0]                        out_awburst,
  input  logic                              out_wready,
  output logic                              out_wvalid,
  output logic [axi_delay_pkg::DATA_W-1:0]  out_wdata,
  output logic [axi_delay_pkg::STRB_W-1:0]  out_wstrb,
  output logic                              out_wlast,
  output logic                              out_bready,
  input  logic                              out_bvalid,
  input  logic [axi_delay_pkg::ID_W-1:0]    out_bid,
  input  logic [axi_delay_pkg::RESP_W-1:0]  out_bresp
);

  logic [1:0]                        state;
  logic                              is_rd;  // delayed transaction is a read.
  logic [axi_delay_pkg::CNT_W-1:0]   cnt;
  logic [axi_delay_pkg::BEAT_W-1:0]  beat_cnt;
  logic [axi_delay_pkg::BEAT_W-1:0]  beat_idx;
  logic [axi_delay_pkg::DATA_W-1:0]  rbuf [axi_delay_pkg::BUF_DEPTH];
  logic [axi_delay_pkg::ID_W-1:0]    rid_q;
  logic [axi_delay_pkg::ID_W-1:0]    bid_q;
  logic [axi_delay_pkg::RESP_W-1:0]  rresp_q;
  logic [axi_delay_pkg::RESP_W-1:0]  bresp_q;
  axi_delay_pkg::axi_addr_u          ar_addr;
  axi_delay_pkg::axi_addr_u          aw_addr;
  logic idle, in_wait, ar_fire, aw_fire, ar_slow, aw_slow;
  logic cap_r, cap_b, req_done, replay_valid, replay_last, wait_done;

  assign idle = (state == axi_delay_pkg::ST_IDLE);
  assign in_wait = (state == axi_delay_pkg::ST_WAIT);

  assign ar_addr = in_araddr;
  assign aw_addr = in_awaddr;
  assign ar_slow = (ar_addr.region_view.region >= axi_delay_pkg::DELAY_REGION_LO) &&
                   (ar_addr.region_view.region <= axi_delay_pkg::DELAY_REGION_HI);
  assign aw_slow = (aw_addr.region_view.region >= axi_delay_pkg::DELAY_REGION_LO) &&
                   (aw_addr.region_view.region <= axi_delay_pkg::DELAY_REGION_HI);

  // new addresses only in IDLE; read wins a same-cycle tie.
  assign out_arvalid = in_arvalid & idle;
  assign in_arready = out_arready & idle;
  assign ar_fire = out_arvalid & out_arready;
  assign out_awvalid = in_awvalid & idle & ~ar_fire;
  assign in_awready = out_awready & idle & ~ar_fire;
  assign aw_fire = out_awvalid & out_awready;

  assign out_arid = in_arid;
  assign out_araddr = in_araddr;
  assign out_arlen = in_arlen;
  assign out_arsize = in_arsize;
  assign out_arburst = in_arburst;
  assign out_awid = in_awid;
  assign out_awaddr = in_awaddr;
  assign out_awlen = in_awlen;
  assign out_awsize = in_awsize;
  assign out_awburst = in_awburst;

  assign out_wvalid = in_wvalid;
  assign out_wdata = in_wdata;
  assign out_wstrb = in_wstrb;
  assign out_wlast = in_wlast;
  assign in_wready = out_wready;

  // readies are high in REQ, so valid alone is a transfer.
  assign cap_r = (state == axi_delay_pkg::ST_REQ) & is_rd & out_rvalid;
  assign cap_b = (state == axi_delay_pkg::ST_REQ) & ~is_rd & out_bvalid;
  assign req_done = (cap_r & out_rlast) | cap_b;

  assign replay_last = (cnt == axi_delay_pkg::CNT_W'(1));
  assign replay_valid = in_wait & is_rd & (cnt <= axi_delay_pkg::CNT_W'(beat_cnt));
  assign beat_idx = beat_cnt - cnt[axi_delay_pkg::BEAT_W-1:0];  // oldest beat first.
  assign wait_done = is_rd ? (replay_valid & replay_last & in_rready)
                           : (replay_last & in_bready);

  assign out_rready = idle ? in_rready : (state == axi_delay_pkg::ST_REQ);
  assign out_bready = idle ? in_bready : (state == axi_delay_pkg::ST_REQ);

  assign in_rvalid = idle ? out_rvalid : replay_valid;
  assign in_rid = idle ? out_rid : rid_q;
  assign in_rdata = idle ? out_rdata : rbuf[beat_idx[axi_delay_pkg::BEAT_W-2:0]];
  assign in_rresp = idle ? out_rresp : rresp_q;
  assign in_rlast = idle ? out_rlast : (replay_valid & replay_last);
  assign in_bvalid = idle ? out_bvalid : (in_wait & ~is_rd & replay_last);
  assign in_bid = idle ? out_bid : bid_q;
  assign in_bresp = idle ? out_bresp : bresp_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= axi_delay_pkg::ST_IDLE;
      is_rd <= 1'b0;
    end else begin
      case (state)
        axi_delay_pkg::ST_IDLE: begin
          if (ar_fire && ar_slow) begin
            state <= axi_delay_pkg::ST_REQ;
            is_rd <= 1'b1;
          end else if (aw_fire && aw_slow) begin
            state <= axi_delay_pkg::ST_REQ;
            is_rd <= 1'b0;
          end
        end
        axi_delay_pkg::ST_REQ: if (req_done) state <= axi_delay_pkg::ST_WAIT;
        axi_delay_pkg::ST_WAIT: if (wait_done) state <= axi_delay_pkg::ST_IDLE;
        default: state <= axi_delay_pkg::ST_IDLE;
      endcase
    end
  end

  // scaled busy time, then countdown to the held completion.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cnt <= '0;
    end else if (state == axi_delay_pkg::ST_REQ) begin
      if (req_done)
        cnt <= ((cnt + axi_delay_pkg::CNT_STEP) >> axi_delay_pkg::CNT_SHIFT) - 1'b1;
      else
        cnt <= cnt + axi_delay_pkg::CNT_STEP;
    end else if (in_wait) begin
      if (!replay_last && !(replay_valid && !in_rready))
        cnt <= cnt - 1'b1;  // stalled beat holds.
    end else begin
      cnt <= '0;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset)
      beat_cnt <= '0;
    else if (idle)
      beat_cnt <= '0;
    else if (cap_r && beat_cnt != axi_delay_pkg::BEAT_W'(axi_delay_pkg::BUF_DEPTH))
      beat_cnt <= beat_cnt + 1'b1;
  end

  always_ff @(posedge clock) begin
    if (cap_r) begin
      rbuf[beat_cnt[axi_delay_pkg::BEAT_W-2:0]] <= out_rdata;
      rid_q <= out_rid;
      rresp_q <= out_rresp;
    end
    if (cap_b) begin
      bid_q <= out_bid;
      bresp_q <= out_bresp;
    end
  end

endmodule

/* axi_delay_pkg.sv */
package axi_delay_pkg;

  localparam int ID_W = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int LEN_W = 8;
  localparam int RESP_W = 2;

  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

  localparam int RATIO_R = 4;  // slowdown seen by the master.
  localparam int RATIO_S = 8;  // fractional steps, power of two.
  localparam int CNT_W = 10;
  localparam logic [CNT_W-1:0] CNT_STEP = CNT_W'(RATIO_R * RATIO_S);
  localparam int CNT_SHIFT = $clog2(RATIO_S);

  localparam int BUF_DEPTH = 8;
  localparam int BEAT_W = $clog2(BUF_DEPTH) + 1;

  localparam int MEM_WORDS = 256;
  localparam int WORD_W = $clog2(MEM_WORDS);

  // top nibbles of the delayed region.
  localparam logic [3:0] DELAY_REGION_LO = 4'ha;
  localparam logic [3:0] DELAY_REGION_HI = 4'hb;

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ = 2'd1;
  localparam logic [1:0] ST_WAIT = 2'd2;

  typedef union packed {
    struct packed {
      logic [3:0]        region;
      logic [ADDR_W-5:0] offset;
    } region_view;
    struct packed {
      logic [ADDR_W-WORD_W-3:0] unused;
      logic [WORD_W-1:0]        word;
      logic [1:0]               lane;
    } mem_view;
  } axi_addr_u;

endpackage
